//--- hdl/ic_pkg.sv
// icache geometry: way, thread and index widths shared by the invalidate control
`default_nettype none

package ic_pkg;

   // ------------------------------------------------------------
   // cache geometry
   // ------------------------------------------------------------
   localparam int num_ways    = 4;
   localparam int num_threads = 4;
   localparam int num_cores   = 8;

   // way number and its one-hot form
   typedef logic [1:0]           way_t;
   typedef logic [num_ways-1:0]  way_mask_t;

   // thread id within a core
   typedef logic [1:0]           tid_t;

   // index is address bits 11..5
   // bit 0 selects the 32B word, bit 1 the half of the 128B line
   typedef logic [6:0]           ic_index_t;

   // ------------------------------------------------------------
   // valid-bit array write enables
   // ------------------------------------------------------------
   // four lanes of one bit per way
   // lane 0 word 0 low half, lane 1 word 1 low half
   // lane 2 word 0 high half, lane 3 word 1 high half
   typedef logic [4*num_ways-1:0] icv_wren_t;

endpackage : ic_pkg

`default_nettype wire

//--- hdl/cpx_pkg.sv
// crossbar return packet: layout, field positions and return-type codes
`default_nettype none

package cpx_pkg;

   // ------------------------------------------------------------
   // packet
   // ------------------------------------------------------------
   localparam int cpx_width = 72;

   typedef logic [cpx_width-1:0] cpx_pkt_t;

   // ------------------------------------------------------------
   // header field positions
   // ------------------------------------------------------------
   localparam int rtntype_lo = 0;
   localparam int rtntype_hi = 3;
   localparam int valid_bit  = 4;
   localparam int thread_lo  = 5;
   localparam int thread_hi  = 6;

   // way info reported with a load return
   localparam int wyvld_bit  = 7;
   localparam int way_lo     = 8;
   localparam int way_hi     = 9;

   // store ack: invalidate all ways of one quarter line
   localparam int iinv_bit   = 10;
   localparam int invpa5_bit = 11;

   // invalidate index, carries index bits 6..1
   localparam int inv_idx_lo = 12;
   localparam int inv_idx_hi = 17;

   // ------------------------------------------------------------
   // invalidate vectors
   // ------------------------------------------------------------
   // one 3-bit entry per word per core, at 18 + 24w + 3c
   // entry bit 0 is valid, bits 2..1 the way
   // bits 71..66 are spare
   localparam int inv_vec_lo      = 18;
   localparam int inv_word_stride = 24;
   localparam int inv_core_stride = 3;
   localparam int inv_ent_vld     = 0;
   localparam int inv_ent_way_lo  = 1;
   localparam int inv_ent_way_hi  = 2;

   // ------------------------------------------------------------
   // return-type codes
   // ------------------------------------------------------------
   localparam logic [3:0] rtn_load      = 4'd0;
   localparam logic [3:0] rtn_ifill     = 4'd1;
   localparam logic [3:0] rtn_evict     = 4'd3;
   localparam logic [3:0] rtn_store_ack = 4'd4;
   localparam logic [3:0] rtn_strm_ack  = 4'd6;

endpackage : cpx_pkg

`default_nettype wire

//--- hdl/cpx_decode.sv
// cpx decode classifies the return packet and pulls out this core's invalidate entries
`timescale 1ns/10ps
`default_nettype none

module cpx_decode #(
   parameter int core_id = 0
) (
   input  wire cpx_pkg::cpx_pkt_t cpx_pkt,
   output logic                   is_ld_inv,
   output ic_pkg::way_t           ld_inv_way,
   output logic                   is_ifill,
   output logic                   is_inv_src,
   output logic                   is_store_iinv,
   output logic                   inv_pa5,
   output ic_pkg::tid_t           pkt_tid,
   output ic_pkg::ic_index_t      inv_index,
   output logic                   word0_inv,
   output logic                   word1_inv,
   output ic_pkg::way_t           word0_way,
   output ic_pkg::way_t           word1_way
);

   logic [3:0] rtntype;
   logic       pkt_vld;
   logic       is_load;
   logic       is_evict;
   logic       is_store;
   logic       is_strm;

   // ------------------------------------------------------------
   // return type
   // ------------------------------------------------------------
   assign rtntype = cpx_pkt[cpx_pkg::rtntype_hi:cpx_pkg::rtntype_lo];
   assign pkt_vld = cpx_pkt[cpx_pkg::valid_bit];

   // each type only counts with the valid bit
   assign is_load  = pkt_vld & (rtntype == cpx_pkg::rtn_load);
   assign is_ifill = pkt_vld & (rtntype == cpx_pkg::rtn_ifill);
   assign is_evict = pkt_vld & (rtntype == cpx_pkg::rtn_evict);
   assign is_store = pkt_vld & (rtntype == cpx_pkg::rtn_store_ack);
   assign is_strm  = pkt_vld & (rtntype == cpx_pkg::rtn_strm_ack);

   // any packet that can carry invalidate vectors
   assign is_inv_src = is_evict | is_store | is_strm;

   // load that hit in the icache and its reported way
   assign is_ld_inv  = is_load & cpx_pkt[cpx_pkg::wyvld_bit];
   assign ld_inv_way = cpx_pkt[cpx_pkg::way_hi:cpx_pkg::way_lo];

   // store ack wiping a whole quarter line
   assign is_store_iinv = is_store & cpx_pkt[cpx_pkg::iinv_bit];
   assign inv_pa5       = cpx_pkt[cpx_pkg::invpa5_bit];

   assign pkt_tid = cpx_pkt[cpx_pkg::thread_hi:cpx_pkg::thread_lo];

   // packet index is 64B aligned so the word bit is always 0
   assign inv_index = {cpx_pkt[cpx_pkg::inv_idx_hi:cpx_pkg::inv_idx_lo], 1'b0};

   // ------------------------------------------------------------
   // this core's slice of the invalidate vectors
   // ------------------------------------------------------------
   // 8:1 mux per word selected by the constant core number
   always_comb begin
      word0_inv = 1'b0;
      word1_inv = 1'b0;
      word0_way = '0;
      word1_way = '0;
      for (int c = 0; c < ic_pkg::num_cores; c++) begin
         if (c == core_id) begin
            // word 0 entry
            word0_inv = cpx_pkt[cpx_pkg::inv_vec_lo + cpx_pkg::inv_core_stride*c
                                + cpx_pkg::inv_ent_vld];
            word0_way = cpx_pkt[cpx_pkg::inv_vec_lo + cpx_pkg::inv_core_stride*c
                                + cpx_pkg::inv_ent_way_lo
                                +: (cpx_pkg::inv_ent_way_hi - cpx_pkg::inv_ent_way_lo + 1)];
            // word 1 entry one word stride further
            word1_inv = cpx_pkt[cpx_pkg::inv_vec_lo + cpx_pkg::inv_word_stride
                                + cpx_pkg::inv_core_stride*c
                                + cpx_pkg::inv_ent_vld];
            word1_way = cpx_pkt[cpx_pkg::inv_vec_lo + cpx_pkg::inv_word_stride
                                + cpx_pkg::inv_core_stride*c
                                + cpx_pkg::inv_ent_way_lo
                                +: (cpx_pkg::inv_ent_way_hi - cpx_pkg::inv_ent_way_lo + 1)];
         end
      end
   end

endmodule : cpx_decode

`default_nettype wire

//--- hdl/ld_index_track.sv
// load index tracker: remembers the icache index of each thread's last load
`timescale 1ns/10ps
`default_nettype none

module ld_index_track (
   input  wire                    rclk,
   input  wire                    rst,
   input  wire                    ld_req_vld,
   input  wire ic_pkg::tid_t      ld_req_tid,
   input  wire ic_pkg::ic_index_t ld_req_index,
   input  wire ic_pkg::tid_t      rd_tid,
   output ic_pkg::ic_index_t      rd_index
);

   // one index per thread
   ic_pkg::ic_index_t ld_idx [ic_pkg::num_threads];

   // ------------------------------------------------------------
   // record on load issue
   // ------------------------------------------------------------
   always_ff @(posedge rclk) begin
      if (rst) begin
         for (int t = 0; t < ic_pkg::num_threads; t++) begin
            ld_idx[t] <= '0;
         end
      end else if (ld_req_vld) begin
         // newest load of the thread replaces the old one
         ld_idx[ld_req_tid] <= ld_req_index;
      end
   end

   // ------------------------------------------------------------
   // read by return packet thread
   // ------------------------------------------------------------
   // a load recorded at one edge shows up the cycle after
   assign rd_index = ld_idx[rd_tid];

endmodule : ld_index_track

`default_nettype wire

//--- hdl/icv_write_ctl.sv
// icv write control: picks ways, word enables and index for valid-bit writes and invalidates
`timescale 1ns/10ps
`default_nettype none

module icv_write_ctl (
   input  wire                    rclk,
   input  wire                    rst,
   input  wire                    ifq_adv,
   input  wire                    asi_req,
   input  wire                    is_ld_inv,
   input  wire ic_pkg::way_t      ld_inv_way,
   input  wire                    is_ifill,
   input  wire                    is_inv_src,
   input  wire                    is_store_iinv,
   input  wire                    inv_pa5,
   input  wire ic_pkg::ic_index_t inv_index,
   input  wire                    word0_inv,
   input  wire                    word1_inv,
   input  wire ic_pkg::way_t      word0_way,
   input  wire ic_pkg::way_t      word1_way,
   input  wire ic_pkg::ic_index_t ld_index,
   input  wire ic_pkg::way_t      cpx_wr_way,
   input  wire ic_pkg::ic_index_t fill_index,
   output ic_pkg::icv_wren_t      icv_wren,
   output ic_pkg::ic_index_t      icv_wr_index,
   output logic                   inv_req,
   output logic                   inv_pending
);

   logic              wr_req;
   logic              pick_wr;
   logic              inv_all;
   ic_pkg::way_t      inv0_way;
   ic_pkg::way_t      inv1_way;
   ic_pkg::way_t      w0_way;
   ic_pkg::way_t      w1_way;
   ic_pkg::way_t      w0_way_q;
   ic_pkg::way_t      w1_way_q;
   ic_pkg::way_mask_t w0_dec;
   ic_pkg::way_mask_t w1_dec;
   logic [3:0]        wd_en_new;
   logic [3:0]        wd_en;
   logic [3:0]        wd_en_q;
   logic              inv_req_q;

   // binary way to one-hot
   function automatic ic_pkg::way_mask_t dec_way(input ic_pkg::way_t w);
      dec_way = ic_pkg::way_mask_t'(1) << w;
   endfunction

   // ------------------------------------------------------------
   // way selection
   // ------------------------------------------------------------
   // fill return or asi write sets a valid bit
   assign wr_req  = is_ifill | asi_req;
   assign pick_wr = wr_req & ifq_adv;

   // stall recirculates, load inv uses the reported way
   assign inv0_way = !ifq_adv  ? w0_way_q   :
                     is_ld_inv ? ld_inv_way : word0_way;
   assign inv1_way = !ifq_adv  ? w1_way_q   :
                     is_ld_inv ? ld_inv_way : word1_way;

   assign w0_way = pick_wr ? cpx_wr_way : inv0_way;
   assign w1_way = pick_wr ? cpx_wr_way : inv1_way;

   assign w0_dec = dec_way(w0_way);
   assign w1_dec = dec_way(w1_way);

   // ------------------------------------------------------------
   // word enables per lane
   // ------------------------------------------------------------
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         // lane k: bit 0 is the word, bit 1 the half
         wd_en_new[k] =
            (is_inv_src & (k[0] ? word1_inv : word0_inv) & (inv_index[1] == k[1])) |
            (is_ld_inv & (ld_index[0] == k[0]) & (ld_index[1] == k[1])) |
            (wr_req & (fill_index[0] == k[0]) & (fill_index[1] == k[1]));
      end
   end

   // hold the enables while the queue is stuck
   assign wd_en = ifq_adv ? wd_en_new : wd_en_q;

   // ------------------------------------------------------------
   // final icv write enables
   // ------------------------------------------------------------
   // all-ways clear only as the store ack leaves the queue
   assign inv_all = is_store_iinv & ifq_adv;

   always_comb begin
      for (int k = 0; k < 4; k++) begin
         icv_wren[4*k +: 4] =
            ((k[0] ? w1_dec : w0_dec) & {4{wd_en[k]}}) |
            {4{inv_all & (inv_pa5 == k[0]) & (inv_index[1] == k[1])}};
      end
   end

   // ------------------------------------------------------------
   // write index
   // ------------------------------------------------------------
   always_comb begin
      if (wr_req || !ifq_adv) begin
         icv_wr_index = fill_index;
      end else if (is_ld_inv) begin
         icv_wr_index = ld_index;
      end else begin
         icv_wr_index = inv_index;
      end
   end

   // ------------------------------------------------------------
   // invalidate request to fetch control
   // ------------------------------------------------------------
   assign inv_pending = (is_inv_src & (word0_inv | word1_inv)) |
                        is_store_iinv | is_ld_inv;

   assign inv_req = ifq_adv ? inv_pending : inv_req_q;

   // held state, rewritten every edge
   always_ff @(posedge rclk) begin
      if (rst) begin
         w0_way_q  <= '0;
         w1_way_q  <= '0;
         wd_en_q   <= '0;
         inv_req_q <= 1'b0;
      end else begin
         w0_way_q  <= w0_way;
         w1_way_q  <= w1_way;
         wd_en_q   <= wd_en;
         inv_req_q <= inv_req;
      end
   end

endmodule : icv_write_ctl

`default_nettype wire

//--- hdl/ifu_invctl.sv
// icache invalidate control top: decode, load index tracking and icv write control
`timescale 1ns/10ps
`default_nettype none

module ifu_invctl #(
   parameter int core_id = 0
) (
   input  wire                    rclk,
   input  wire                    rst,
   input  wire cpx_pkg::cpx_pkt_t cpx_pkt,
   input  wire ic_pkg::way_t      cpx_wr_way,
   input  wire ic_pkg::ic_index_t fill_index,
   input  wire                    ifq_adv,
   input  wire                    asi_req,
   input  wire                    ld_req_vld,
   input  wire ic_pkg::tid_t      ld_req_tid,
   input  wire ic_pkg::ic_index_t ld_req_index,
   output ic_pkg::icv_wren_t      icv_wren,
   output ic_pkg::ic_index_t      icv_wr_index,
   output logic                   inv_req,
   output logic                   inv_pending
);

   // decoded packet fields
   logic              is_ld_inv;
   ic_pkg::way_t      ld_inv_way;
   logic              is_ifill;
   logic              is_inv_src;
   logic              is_store_iinv;
   logic              inv_pa5;
   ic_pkg::tid_t      pkt_tid;
   ic_pkg::ic_index_t inv_index;
   logic              word0_inv;
   logic              word1_inv;
   ic_pkg::way_t      word0_way;
   ic_pkg::way_t      word1_way;

   // index of the returning thread's load
   ic_pkg::ic_index_t ld_index;

   // ------------------------------------------------------------
   // packet decode
   // ------------------------------------------------------------
   cpx_decode #(
      .core_id (core_id)
   ) i_cpx_decode (
      .cpx_pkt       (cpx_pkt),
      .is_ld_inv     (is_ld_inv),
      .ld_inv_way    (ld_inv_way),
      .is_ifill      (is_ifill),
      .is_inv_src    (is_inv_src),
      .is_store_iinv (is_store_iinv),
      .inv_pa5       (inv_pa5),
      .pkt_tid       (pkt_tid),
      .inv_index     (inv_index),
      .word0_inv     (word0_inv),
      .word1_inv     (word1_inv),
      .word0_way     (word0_way),
      .word1_way     (word1_way)
   );

   // ------------------------------------------------------------
   // per-thread load index
   // ------------------------------------------------------------
   ld_index_track i_ld_index_track (
      .rclk         (rclk),
      .rst          (rst),
      .ld_req_vld   (ld_req_vld),
      .ld_req_tid   (ld_req_tid),
      .ld_req_index (ld_req_index),
      .rd_tid       (pkt_tid),
      .rd_index     (ld_index)
   );

   // ------------------------------------------------------------
   // valid-bit write control
   // ------------------------------------------------------------
   icv_write_ctl i_icv_write_ctl (
      .rclk          (rclk),
      .rst           (rst),
      .ifq_adv       (ifq_adv),
      .asi_req       (asi_req),
      .is_ld_inv     (is_ld_inv),
      .ld_inv_way    (ld_inv_way),
      .is_ifill      (is_ifill),
      .is_inv_src    (is_inv_src),
      .is_store_iinv (is_store_iinv),
      .inv_pa5       (inv_pa5),
      .inv_index     (inv_index),
      .word0_inv     (word0_inv),
      .word1_inv     (word1_inv),
      .word0_way     (word0_way),
      .word1_way     (word1_way),
      .ld_index      (ld_index),
      .cpx_wr_way    (cpx_wr_way),
      .fill_index    (fill_index),
      .icv_wren      (icv_wren),
      .icv_wr_index  (icv_wr_index),
      .inv_req       (inv_req),
      .inv_pending   (inv_pending)
   );

endmodule : ifu_invctl

`default_nettype wire

//--- tb/tb_ifu_invctl.sv
// invalidate control testbench driving random fills, invalidates, load returns and stalls
`timescale 1ns/10ps
`default_nettype none

module tb_ifu_invctl;

   localparam int dut_core    = 5;
   localparam int n_idle      = 6;
   localparam int n_fill      = 48;
   localparam int n_inv       = 64;
   localparam int n_load      = 48;
   localparam int n_iinv      = 24;
   localparam int n_stall     = 32;
   localparam int max_stall   = 8;
   // reset plus every test loop at its longest plus a short tail
   localparam int test_cycles = 8 + n_idle + n_fill + n_inv + 2*n_load + n_iinv
                                + (max_stall + 1)*n_stall + 4;
   localparam int timeout_ns  = test_cycles * 8 * 2;

   logic              rclk;
   logic              rst;
   cpx_pkg::cpx_pkt_t cpx_pkt;
   ic_pkg::way_t      cpx_wr_way;
   ic_pkg::ic_index_t fill_index;
   logic              ifq_adv;
   logic              asi_req;
   logic              ld_req_vld;
   ic_pkg::tid_t      ld_req_tid;
   ic_pkg::ic_index_t ld_req_index;
   ic_pkg::icv_wren_t icv_wren;
   ic_pkg::ic_index_t icv_wr_index;
   logic              inv_req;
   logic              inv_pending;

   logic [31:0]       lfsr_state;

   // model of the per-thread load index and the held registers
   ic_pkg::ic_index_t ld_model [4];
   ic_pkg::way_t      held_w0;
   ic_pkg::way_t      held_w1;
   logic [3:0]        held_en;
   logic              held_req;

   // expected outputs and next held values of the current cycle
   ic_pkg::icv_wren_t exp_wren;
   ic_pkg::ic_index_t exp_index;
   logic              exp_req;
   logic              exp_pend;
   ic_pkg::way_t      nxt_w0;
   ic_pkg::way_t      nxt_w1;
   logic [3:0]        nxt_en;

   ifu_invctl #(
      .core_id (dut_core)
   ) i_dut (
      .rclk         (rclk),
      .rst          (rst),
      .cpx_pkt      (cpx_pkt),
      .cpx_wr_way   (cpx_wr_way),
      .fill_index   (fill_index),
      .ifq_adv      (ifq_adv),
      .asi_req      (asi_req),
      .ld_req_vld   (ld_req_vld),
      .ld_req_tid   (ld_req_tid),
      .ld_req_index (ld_req_index),
      .icv_wren     (icv_wren),
      .icv_wr_index (icv_wr_index),
      .inv_req      (inv_req),
      .inv_pending  (inv_pending)
   );

   // 8 ns clock
   initial rclk = 1'b0;
   always #4 rclk = ~rclk;

   // ------------------------------------------------------------
   // random numbers
   // ------------------------------------------------------------
   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          b;
      r = '0;
      for (b = 0; b < n; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[31]};
      end
      return r;
   endfunction

   // random packet with given type and valid and with iinv clear
   function automatic cpx_pkg::cpx_pkt_t random_pkt(input logic [3:0] code, input logic vld);
      logic [31:0]       hi;
      logic [31:0]       mid;
      logic [31:0]       lo;
      cpx_pkg::cpx_pkt_t p;
      hi = rand_bits(8);
      mid = rand_bits(32);
      lo = rand_bits(32);
      p = {hi[7:0], mid, lo};
      p[3:0] = code;
      p[4] = vld;
      p[10] = 1'b0;
      return p;
   endfunction

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------
   function automatic void expected_outputs(
      input cpx_pkg::cpx_pkt_t pkt,
      input ic_pkg::way_t      wr_way,
      input ic_pkg::ic_index_t fidx,
      input logic              adv,
      input logic              asi
   );
      logic              ld_inv;
      logic              src;
      logic              st_iinv;
      logic              wr;
      logic              inv0;
      logic              inv1;
      logic              wsel;
      logic              hsel;
      ic_pkg::ic_index_t iidx;
      ic_pkg::ic_index_t lidx;
      ic_pkg::way_t      way_k;
      int                k;
      // header fields at their packet positions
      ld_inv  = pkt[4] && pkt[3:0] == cpx_pkg::rtn_load && pkt[7];
      src     = pkt[4] && (pkt[3:0] == cpx_pkg::rtn_evict || pkt[3:0] == cpx_pkg::rtn_store_ack
                           || pkt[3:0] == cpx_pkg::rtn_strm_ack);
      st_iinv = pkt[4] && pkt[3:0] == cpx_pkg::rtn_store_ack && pkt[10];
      wr      = (pkt[4] && pkt[3:0] == cpx_pkg::rtn_ifill) || asi;
      iidx    = {pkt[17:12], 1'b0};
      lidx    = ld_model[pkt[6:5]];
      // core entry of word w at 18 + 24w + 3c with valid below way
      inv0    = pkt[18 + 3*dut_core];
      inv1    = pkt[42 + 3*dut_core];
      if (!adv) begin
         nxt_w0 = held_w0;
         nxt_w1 = held_w1;
      end else if (wr) begin
         nxt_w0 = wr_way;
         nxt_w1 = wr_way;
      end else if (ld_inv) begin
         nxt_w0 = pkt[9:8];
         nxt_w1 = pkt[9:8];
      end else begin
         nxt_w0 = pkt[19 + 3*dut_core +: 2];
         nxt_w1 = pkt[43 + 3*dut_core +: 2];
      end
      // lane k has the word in bit 0 and the half in bit 1
      for (k = 0; k < 4; k++) begin
         wsel = k[0];
         hsel = k[1];
         nxt_en[k] = (src && (wsel ? inv1 : inv0) && iidx[1] == hsel)
                     || (ld_inv && lidx[1:0] == {hsel, wsel})
                     || (wr && fidx[1:0] == {hsel, wsel});
         if (!adv) begin
            nxt_en[k] = held_en[k];
         end
         way_k = wsel ? nxt_w1 : nxt_w0;
         exp_wren[4*k +: 4] = (nxt_en[k] ? 4'b0001 << way_k : 4'b0000)
            | ((st_iinv && adv && pkt[11] == wsel && iidx[1] == hsel) ? 4'b1111 : 4'b0000);
      end
      if (wr || !adv) begin
         exp_index = fidx;
      end else if (ld_inv) begin
         exp_index = lidx;
      end else begin
         exp_index = iidx;
      end
      exp_pend = (src && (inv0 || inv1)) || st_iinv || ld_inv;
      exp_req  = adv ? exp_pend : held_req;
   endfunction

   // ------------------------------------------------------------
   // checking
   // ------------------------------------------------------------
   task automatic compare_value(input string sig, input logic [15:0] got,
                                input logic [15:0] want);
      if (got !== want) begin
         $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h", $time, sig, want, got);
         $display("sim failed");
         $fatal(1, "output mismatch");
      end
   endtask

   // outputs settle after the falling edge and are sampled at the rising edge
   always @(posedge rclk) begin
      if (rst) begin
         held_w0  = '0;
         held_w1  = '0;
         held_en  = '0;
         held_req = 1'b0;
         foreach (ld_model[t]) begin
            ld_model[t] = '0;
         end
      end else begin
         expected_outputs(cpx_pkt, cpx_wr_way, fill_index, ifq_adv, asi_req);
         compare_value("icv_wren", icv_wren, exp_wren);
         compare_value("icv_wr_index", 16'(icv_wr_index), 16'(exp_index));
         compare_value("inv_req", 16'(inv_req), 16'(exp_req));
         compare_value("inv_pending", 16'(inv_pending), 16'(exp_pend));
         held_w0  = nxt_w0;
         held_w1  = nxt_w1;
         held_en  = nxt_en;
         held_req = exp_req;
         if (ld_req_vld) begin
            ld_model[ld_req_tid] = ld_req_index;
         end
      end
   end

   // watchdog
   initial begin
      #(timeout_ns);
      $display("watchdog expired after %0d ns, the stimulus never finished", timeout_ns);
      $display("sim failed");
      $fatal(1, "timeout");
   end

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------
   // one cycle of inputs with random fill way, fill index and load fields
   task automatic drive_cycle(input cpx_pkg::cpx_pkt_t pkt, input logic adv, input logic asi,
                              input logic ld_vld);
      @(negedge rclk);
      cpx_pkt      = pkt;
      ifq_adv      = adv;
      asi_req      = asi;
      cpx_wr_way   = ic_pkg::way_t'(rand_bits(2));
      fill_index   = ic_pkg::ic_index_t'(rand_bits(7));
      ld_req_vld   = ld_vld;
      ld_req_tid   = ic_pkg::tid_t'(rand_bits(2));
      ld_req_index = ic_pkg::ic_index_t'(rand_bits(7));
   endtask

   initial begin
      int                i;
      int                len;
      logic [1:0]        kind;
      logic [3:0]        code;
      ic_pkg::tid_t      tid_last;
      cpx_pkg::cpx_pkt_t pkt;
      lfsr_state   = 32'hfac4_7fb1;
      rst          = 1'b1;
      cpx_pkt      = '0;
      cpx_wr_way   = '0;
      fill_index   = '0;
      ifq_adv      = 1'b0;
      asi_req      = 1'b0;
      ld_req_vld   = 1'b0;
      ld_req_tid   = '0;
      ld_req_index = '0;
      repeat (8) @(posedge rclk);
      @(negedge rclk);
      rst = 1'b0;

      // idle queue right after reset
      repeat (n_idle) drive_cycle('0, 1'b1, 1'b0, 1'b0);

      // fill returns, asi writes, or both together
      for (i = 0; i < n_fill; i++) begin
         kind = 2'(rand_bits(2));
         pkt  = random_pkt(cpx_pkg::rtn_ifill, kind != 2'd0);
         drive_cycle(pkt, 1'b1, kind != 2'd1, 1'(rand_bits(1)));
      end

      // evict, store ack, stream ack with vectors for all cores
      for (i = 0; i < n_inv; i++) begin
         kind = 2'(rand_bits(2));
         code = (kind == 2'd1) ? cpx_pkg::rtn_store_ack :
                (kind == 2'd2) ? cpx_pkg::rtn_strm_ack : cpx_pkg::rtn_evict;
         drive_cycle(random_pkt(code, 1'b1), 1'b1, 1'b0, 1'(rand_bits(1)));
      end

      // load issue followed by a load return one cycle later
      for (i = 0; i < n_load; i++) begin
         drive_cycle('0, 1'b1, 1'b0, 1'b1);
         tid_last = ld_req_tid;
         pkt = random_pkt(cpx_pkg::rtn_load, 1'b1);
         pkt[7] = 2'(rand_bits(2)) != 2'd0;
         // half the time the thread that just issued
         if (rand_bits(1) == 32'd1) begin
            pkt[6:5] = tid_last;
         end
         drive_cycle(pkt, 1'b1, 1'b0, 1'(rand_bits(1)));
      end

      // store acks clearing all ways of a quarter line
      for (i = 0; i < n_iinv; i++) begin
         pkt = random_pkt(cpx_pkg::rtn_store_ack, 1'b1);
         pkt[10] = 1'b1;
         drive_cycle(pkt, 1'b1, 1'b0, 1'(rand_bits(1)));
      end

      // packet stuck at the head until it advances
      for (i = 0; i < n_stall; i++) begin
         kind = 2'(rand_bits(2));
         case (kind)
            2'd0: pkt = random_pkt(cpx_pkg::rtn_ifill, 1'b1);
            2'd1: begin
               pkt = random_pkt(cpx_pkg::rtn_store_ack, 1'b1);
               pkt[10] = 1'(rand_bits(1));
            end
            2'd2: begin
               pkt = random_pkt(cpx_pkg::rtn_load, 1'b1);
               pkt[7] = 1'b1;
            end
            default: pkt = random_pkt(cpx_pkg::rtn_evict, 1'b0);
         endcase
         len = 1 + int'(rand_bits(3));
         repeat (len) drive_cycle(pkt, 1'b0, kind == 2'd3, 1'(rand_bits(1)));
         drive_cycle(pkt, 1'b1, kind == 2'd3, 1'(rand_bits(1)));
      end

      drive_cycle('0, 1'b1, 1'b0, 1'b0);
      @(negedge rclk);
      $display("sim passed");
      $finish;
   end

endmodule : tb_ifu_invctl

`default_nettype wire

//--- ifu_invctl.f
hdl/ic_pkg.sv
hdl/cpx_pkg.sv
hdl/cpx_decode.sv
hdl/ld_index_track.sv
hdl/icv_write_ctl.sv
hdl/ifu_invctl.sv
tb/tb_ifu_invctl.sv

//--- Makefile
TOP = tb_ifu_invctl

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f ifu_invctl.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
